// File: source/coreTypes.sv
// package with core widths, opcodes, ALU operations and stage payload structs
`default_nettype none

package coreTypes;

    localparam int xlen = 32;
    localparam int regAddrWidth = 5;
    localparam logic [31:0] resetPc = 32'h0000_0000;

    // RV32I major opcodes of the supported subset
    localparam logic [6:0] opLui = 7'b0110111;
    localparam logic [6:0] opImm = 7'b0010011;
    localparam logic [6:0] opReg = 7'b0110011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal = 7'b1101111;

    typedef enum logic [3:0] {
        aluAdd = 4'd0,
        aluSub = 4'd1,
        aluAnd = 4'd2,
        aluOr = 4'd3,
        aluXor = 4'd4,
        aluSlt = 4'd5,
        aluPassB = 4'd6   // LUI just forwards the immediate
    } aluOpT;

    // IF/ID
    typedef struct packed {
        logic valid;
        logic [xlen-1:0] pc;
        logic [31:0] inst;
    } fetchPayloadT;

    // ID/EX
    typedef struct packed {
        logic valid;
        logic [xlen-1:0] pc;
        logic [regAddrWidth-1:0] rs1;
        logic [regAddrWidth-1:0] rs2;
        logic [regAddrWidth-1:0] rd;
        logic [xlen-1:0] rs1Value;
        logic [xlen-1:0] rs2Value;
        logic [xlen-1:0] imm;
        aluOpT aluOp;
        logic useImm;
        logic isBranch;
        logic branchNe;   // BNE when set, BEQ otherwise
        logic isJal;
        logic writesRd;
    } decodePayloadT;

    // EX/retire
    typedef struct packed {
        logic valid;
        logic [xlen-1:0] pc;
        logic [regAddrWidth-1:0] rd;
        logic writesRd;
        logic [xlen-1:0] data;
    } retirePayloadT;

endpackage

`default_nettype wire

// File: source/writebackIf.sv
// interface for the write-back bus from retire to register file and forwarding
`default_nettype none
`timescale 1ns/10ps

interface writebackIf import coreTypes::*; ();

    logic valid;
    logic [regAddrWidth-1:0] rd;
    logic [xlen-1:0] data;

    modport source (
        output valid,
        output rd,
        output data
    );

    // register file write port
    modport sink (
        input valid,
        input rd,
        input data
    );

    // execute stage forwarding
    modport monitor (
        input valid,
        input rd,
        input data
    );

endinterface

`default_nettype wire

// File: source/stageRegister.sv
// generic pipeline register with hold on stall and bubble on flush
`default_nettype none
`timescale 1ns/10ps

module stageRegister import coreTypes::*; #(
    parameter type payloadT = fetchPayloadT
) (
    input logic clk,
    input logic reset,
    input logic advance,
    input logic flush,
    input payloadT din,
    output payloadT dout
);

    payloadT bubble;

    // same payload, slot marked empty
    always_comb begin
        bubble = din;
        bubble.valid = 1'b0;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dout <= '0;
        end else if (advance) begin
            dout <= flush ? bubble : din;
        end
    end

endmodule

`default_nettype wire

// File: source/fetchUnit.sv
// program counter with sequential advance, redirect and hold
`default_nettype none
`timescale 1ns/10ps

module fetchUnit import coreTypes::*; (
    input logic clk,
    input logic reset,
    input logic advance,
    input logic fetchReady,
    input logic redirect,
    input logic [xlen-1:0] redirectTarget,
    output logic [xlen-1:0] fetchAddr
);

    logic [xlen-1:0] pc;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= resetPc;
        end else if (advance) begin
            if (redirect) begin
                pc <= redirectTarget;   // taken branch or jump wins
            end else if (fetchReady) begin
                pc <= pc + 32'd4;
            end
        end
    end

    assign fetchAddr = pc;

endmodule

`default_nettype wire

// File: source/registerFile.sv
// 32 x 32-bit register file, two read ports, one write port with write-through
`default_nettype none
`timescale 1ns/10ps

module registerFile import coreTypes::*; (
    input logic clk,
    input logic reset,
    input logic [regAddrWidth-1:0] readAddr1,
    input logic [regAddrWidth-1:0] readAddr2,
    output logic [xlen-1:0] readData1,
    output logic [xlen-1:0] readData2,
    writebackIf.sink writeback
);

    logic [xlen-1:0] regs [32];
    logic writeActive;

    // x0 is never written
    assign writeActive = writeback.valid && (writeback.rd != '0);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            regs <= '{default: '0};
        end else if (writeActive) begin
            regs[writeback.rd] <= writeback.data;
        end
    end

    // same-cycle write shows up on the read ports
    assign readData1 = (writeActive && writeback.rd == readAddr1) ? writeback.data
                                                                  : regs[readAddr1];
    assign readData2 = (writeActive && writeback.rd == readAddr2) ? writeback.data
                                                                  : regs[readAddr2];

endmodule

`default_nettype wire

// File: source/decodeUnit.sv
// instruction decode: fields, immediates, control flags and register reads
`default_nettype none
`timescale 1ns/10ps

module decodeUnit import coreTypes::*; (
    input fetchPayloadT fetched,
    output logic [regAddrWidth-1:0] readAddr1,
    output logic [regAddrWidth-1:0] readAddr2,
    input logic [xlen-1:0] readData1,
    input logic [xlen-1:0] readData2,
    output decodePayloadT decoded
);

    logic [31:0] inst;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [xlen-1:0] immI;
    logic [xlen-1:0] immB;
    logic [xlen-1:0] immU;
    logic [xlen-1:0] immJ;
    logic supported;

    assign inst = fetched.inst;
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign readAddr1 = inst[19:15];
    assign readAddr2 = inst[24:20];

    assign immI = {{20{inst[31]}}, inst[31:20]};
    assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign immU = {inst[31:12], 12'b0};
    assign immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        supported = 1'b1;
        decoded = '0;
        decoded.pc = fetched.pc;
        decoded.rs1 = readAddr1;
        decoded.rs2 = readAddr2;
        decoded.rd = inst[11:7];
        decoded.rs1Value = readData1;
        decoded.rs2Value = readData2;
        decoded.aluOp = aluAdd;
        case (opcode)
            opLui: begin
                decoded.imm = immU;
                decoded.useImm = 1'b1;
                decoded.aluOp = aluPassB;
                decoded.writesRd = 1'b1;
            end
            opImm: begin
                decoded.imm = immI;
                decoded.useImm = 1'b1;
                decoded.writesRd = 1'b1;
                case (funct3)
                    3'b000: decoded.aluOp = aluAdd;
                    3'b010: decoded.aluOp = aluSlt;
                    3'b100: decoded.aluOp = aluXor;
                    3'b110: decoded.aluOp = aluOr;
                    3'b111: decoded.aluOp = aluAnd;
                    default: supported = 1'b0;   // shifts, sltiu
                endcase
            end
            opReg: begin
                decoded.writesRd = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: decoded.aluOp = aluAdd;
                    10'b0100000_000: decoded.aluOp = aluSub;
                    10'b0000000_010: decoded.aluOp = aluSlt;
                    10'b0000000_100: decoded.aluOp = aluXor;
                    10'b0000000_110: decoded.aluOp = aluOr;
                    10'b0000000_111: decoded.aluOp = aluAnd;
                    default: supported = 1'b0;
                endcase
            end
            opBranch: begin
                decoded.imm = immB;
                decoded.isBranch = 1'b1;
                decoded.branchNe = funct3[0];
                supported = (funct3[2:1] == 2'b00);   // only beq/bne
            end
            opJal: begin
                decoded.imm = immJ;
                decoded.isJal = 1'b1;
                decoded.writesRd = 1'b1;
            end
            default: supported = 1'b0;
        endcase
        decoded.valid = fetched.valid && supported;
    end

endmodule

`default_nettype wire

// File: source/executeUnit.sv
// execute stage: operand forwarding, ALU, branch and jump resolution
`default_nettype none
`timescale 1ns/10ps

module executeUnit import coreTypes::*; (
    input decodePayloadT decoded,
    input retirePayloadT retireStage,
    writebackIf.monitor writeback,
    output logic redirect,
    output logic [xlen-1:0] redirectTarget,
    output retirePayloadT result
);

    logic [xlen-1:0] operand1;
    logic [xlen-1:0] operand2;
    logic [xlen-1:0] aluB;
    logic [xlen-1:0] aluResult;
    logic [xlen-1:0] linkAddr;
    logic branchTaken;
    logic keepRd;

    // youngest producer first, then the write-back bus, then the file value
    function automatic logic [xlen-1:0] pickOperand(
        input logic [regAddrWidth-1:0] rs,
        input logic [xlen-1:0] fileValue,
        input retirePayloadT older,
        input logic wbValid,
        input logic [regAddrWidth-1:0] wbRd,
        input logic [xlen-1:0] wbData
    );
        logic [xlen-1:0] value;
        value = fileValue;
        if (rs != '0) begin
            if (older.valid && older.writesRd && older.rd == rs) begin
                value = older.data;
            end else if (wbValid && wbRd == rs) begin
                value = wbData;
            end
        end
        return value;
    endfunction

    assign operand1 = pickOperand(decoded.rs1, decoded.rs1Value, retireStage,
                                  writeback.valid, writeback.rd, writeback.data);
    assign operand2 = pickOperand(decoded.rs2, decoded.rs2Value, retireStage,
                                  writeback.valid, writeback.rd, writeback.data);
    assign aluB = decoded.useImm ? decoded.imm : operand2;

    always_comb begin
        case (decoded.aluOp)
            aluAdd: aluResult = operand1 + aluB;
            aluSub: aluResult = operand1 - aluB;
            aluAnd: aluResult = operand1 & aluB;
            aluOr: aluResult = operand1 | aluB;
            aluXor: aluResult = operand1 ^ aluB;
            aluSlt: aluResult = {31'b0, $signed(operand1) < $signed(aluB)};
            aluPassB: aluResult = aluB;
            default: aluResult = '0;
        endcase
    end

    // branches compare the raw register operands
    assign branchTaken = decoded.isBranch &&
                         (decoded.branchNe ? (operand1 != operand2) : (operand1 == operand2));
    assign redirect = decoded.valid && (decoded.isJal || branchTaken);
    assign redirectTarget = decoded.pc + decoded.imm;
    assign linkAddr = decoded.pc + 32'd4;

    // writes to x0 retire as non-writing
    assign keepRd = decoded.writesRd && (decoded.rd != '0);

    always_comb begin
        result = '0;
        result.valid = decoded.valid;
        result.pc = decoded.pc;
        result.writesRd = keepRd;
        if (keepRd) begin
            result.rd = decoded.rd;
            result.data = decoded.isJal ? linkAddr : aluResult;
        end
    end

endmodule

`default_nettype wire

// File: source/pipelineCore.sv
// four-stage RV32I core top: fetch, decode, execute and retire wiring
`default_nettype none
`timescale 1ns/10ps

module pipelineCore import coreTypes::*; (
    input logic clk,
    input logic reset,
    output logic [xlen-1:0] fetchAddr,
    input logic [31:0] fetchInst,
    input logic fetchReady,
    output logic retireValid,
    output logic [xlen-1:0] retirePc,
    output logic [regAddrWidth-1:0] retireRd,
    output logic [xlen-1:0] retireData,
    input logic retireReady
);

    fetchPayloadT fetchedIn;
    fetchPayloadT fetchedOut;
    decodePayloadT decodedIn;
    decodePayloadT decodedOut;
    retirePayloadT retireIn;
    retirePayloadT retireOut;

    logic advance;
    logic redirect;
    logic [xlen-1:0] redirectTarget;
    logic [regAddrWidth-1:0] readAddr1;
    logic [regAddrWidth-1:0] readAddr2;
    logic [xlen-1:0] readData1;
    logic [xlen-1:0] readData2;

    writebackIf wbBus ();

    // whole pipe freezes while a retirement waits for acceptance
    assign advance = !(retireOut.valid && !retireReady);

    fetchUnit fetch (
        .clk(clk),
        .reset(reset),
        .advance(advance),
        .fetchReady(fetchReady),
        .redirect(redirect),
        .redirectTarget(redirectTarget),
        .fetchAddr(fetchAddr)
    );

    assign fetchedIn.valid = fetchReady;
    assign fetchedIn.pc = fetchAddr;
    assign fetchedIn.inst = fetchInst;

    stageRegister #(.payloadT(fetchPayloadT)) ifId (
        .clk(clk),
        .reset(reset),
        .advance(advance),
        .flush(redirect),
        .din(fetchedIn),
        .dout(fetchedOut)
    );

    decodeUnit decode (
        .fetched(fetchedOut),
        .readAddr1(readAddr1),
        .readAddr2(readAddr2),
        .readData1(readData1),
        .readData2(readData2),
        .decoded(decodedIn)
    );

    registerFile regFile (
        .clk(clk),
        .reset(reset),
        .readAddr1(readAddr1),
        .readAddr2(readAddr2),
        .readData1(readData1),
        .readData2(readData2),
        .writeback(wbBus)
    );

    stageRegister #(.payloadT(decodePayloadT)) idEx (
        .clk(clk),
        .reset(reset),
        .advance(advance),
        .flush(redirect),
        .din(decodedIn),
        .dout(decodedOut)
    );

    executeUnit execute (
        .decoded(decodedOut),
        .retireStage(retireOut),
        .writeback(wbBus),
        .redirect(redirect),
        .redirectTarget(redirectTarget),
        .result(retireIn)
    );

    // the branch itself always moves on to retire
    stageRegister #(.payloadT(retirePayloadT)) exRetire (
        .clk(clk),
        .reset(reset),
        .advance(advance),
        .flush(1'b0),
        .din(retireIn),
        .dout(retireOut)
    );

    assign wbBus.valid = retireOut.valid && retireOut.writesRd && retireReady;
    assign wbBus.rd = retireOut.rd;
    assign wbBus.data = retireOut.data;

    assign retireValid = retireOut.valid;
    assign retirePc = retireOut.pc;
    assign retireRd = retireOut.rd;
    assign retireData = retireOut.data;

endmodule

`default_nettype wire

// File: verification/retireChecker.sv
// retirement checker with RV32I reference model, reset and stall stability checks
`default_nettype none
`timescale 1ns/10ps

module retireChecker import coreTypes::*; #(
    parameter int progWords = 64
) (
    input logic clk,
    input logic reset,
    input logic [31:0] progMem [progWords],
    input logic [31:0] fetchAddr,
    input logic retireValid,
    input logic [31:0] retirePc,
    input logic [4:0] retireRd,
    input logic [31:0] retireData,
    input logic retireReady,
    output int retiredCount,
    output int errorCount
);

    logic [31:0] modelRegs [32];
    logic [31:0] modelPc = resetPc;
    int retired = 0;
    int errors = 0;
    int sinceReset = 0;
    logic holding = 1'b0;
    logic [31:0] heldPc;
    logic [4:0] heldRd;
    logic [31:0] heldData;

    assign retiredCount = retired;
    assign errorCount = errors;

    task automatic reportValue(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        $display("FAILED %s: got %h, expected %h (model pc %h)", name, got, expected, modelPc);
        errors++;
    endtask

    // one instruction per the ISA; rd comes back 0 when nothing is written
    function automatic void stepModel(
        input logic [31:0] inst,
        input logic [31:0] pc,
        input logic [31:0] a,
        input logic [31:0] b,
        output logic [31:0] nextPc,
        output logic [4:0] rd,
        output logic [31:0] value
    );
        logic [31:0] immI;
        logic [31:0] immB;
        logic [31:0] immJ;
        immI = {{20{inst[31]}}, inst[31:20]};
        immB = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        immJ = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        nextPc = pc + 32'd4;
        rd = inst[11:7];
        value = '0;
        case (inst[6:0])
            opLui: value = {inst[31:12], 12'd0};
            opImm: begin
                case (inst[14:12])
                    3'b000: value = a + immI;
                    3'b010: value = ($signed(a) < $signed(immI)) ? 32'd1 : 32'd0;
                    3'b100: value = a ^ immI;
                    3'b110: value = a | immI;
                    default: value = a & immI;
                endcase
            end
            opReg: begin
                case (inst[14:12])
                    3'b000: value = inst[30] ? a - b : a + b;
                    3'b010: value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    3'b100: value = a ^ b;
                    3'b110: value = a | b;
                    default: value = a & b;
                endcase
            end
            opBranch: begin
                rd = 5'd0;
                if ((a == b) != inst[12]) begin   // funct3 bit 0 flips beq into bne
                    nextPc = pc + immB;
                end
            end
            opJal: begin
                value = pc + 32'd4;
                nextPc = pc + immJ;
            end
            default: rd = 5'd0;
        endcase
        if (rd == 5'd0) begin
            value = '0;
        end
    endfunction

    always @(posedge clk) begin
        logic [31:0] inst;
        logic [31:0] nextPc;
        logic [4:0] rd;
        logic [31:0] value;
        if (reset) begin
            modelRegs = '{default: '0};
            modelPc = resetPc;
            retired = 0;
            sinceReset = 0;
            holding = 1'b0;
            if (retireValid !== 1'b0) reportValue("retireValid", 32'(retireValid), 32'd0);
            if (fetchAddr !== resetPc) reportValue("fetchAddr", fetchAddr, resetPc);
        end else begin
            // nothing can reach retire in the first three cycles
            if (sinceReset < 3) begin
                if (retireValid !== 1'b0) reportValue("retireValid", 32'(retireValid), 32'd0);
                if (sinceReset == 0 && fetchAddr !== resetPc) begin
                    reportValue("fetchAddr", fetchAddr, resetPc);
                end
                sinceReset++;
            end
            if (holding) begin   // stalled outputs must not move
                if (retireValid !== 1'b1) reportValue("retireValid", 32'(retireValid), 32'd1);
                if (retirePc !== heldPc) reportValue("retirePc", retirePc, heldPc);
                if (retireRd !== heldRd) reportValue("retireRd", 32'(retireRd), 32'(heldRd));
                if (retireData !== heldData) reportValue("retireData", retireData, heldData);
            end
            if (retireValid && retireReady) begin
                inst = progMem[int'(modelPc[31:2]) % progWords];
                stepModel(inst, modelPc, modelRegs[inst[19:15]], modelRegs[inst[24:20]],
                          nextPc, rd, value);
                if (retirePc !== modelPc) reportValue("retirePc", retirePc, modelPc);
                if (retireRd !== rd) reportValue("retireRd", 32'(retireRd), 32'(rd));
                if (rd != 5'd0 && retireData !== value) begin
                    reportValue("retireData", retireData, value);
                end
                if (rd != 5'd0) modelRegs[rd] = value;
                modelPc = nextPc;
                retired++;
            end
            holding = retireValid && !retireReady;
            heldPc = retirePc;
            heldRd = retireRd;
            heldData = retireData;
        end
    end

endmodule

`default_nettype wire

// File: verification/coreTb.sv
// testbench top: clock, reset, random program memory, stall stimulus, DUT and checker
`default_nettype none
`timescale 1ns/10ps

module coreTb import coreTypes::*; ();

    localparam int progWords = 64;   // fetch index is fetchAddr[7:2]
    localparam int retireTarget = 90;
    localparam int waitLimit = 5000;
    localparam logic [31:0] seed = 32'h3d1a_9621;

    logic clk = 1'b0;
    logic reset = 1'b1;
    logic [31:0] fetchAddr;
    logic [31:0] fetchInst = '0;
    logic fetchReady = 1'b0;
    logic retireValid;
    logic [31:0] retirePc;
    logic [4:0] retireRd;
    logic [31:0] retireData;
    logic retireReady = 1'b0;

    logic [31:0] progMem [progWords] = '{default: '0};
    logic [31:0] progRng = seed;
    logic [31:0] stallRng = seed ^ 32'h5555_5555;   // own stream for ready stalls
    int fetchStallPct = 0;
    int retireStallPct = 0;
    int retiredCount;
    int errorCount;
    int testsRun = 0;
    int testsBad = 0;

    always #4 clk = ~clk;

    function automatic logic [31:0] nextRandom(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // ready stalls and the instruction for the current fetchAddr
    always @(negedge clk) begin
        stallRng = nextRandom(stallRng);
        fetchReady <= (int'(stallRng[31:24]) % 100) >= fetchStallPct;
        retireReady <= (int'(stallRng[23:16]) % 100) >= retireStallPct;
        if (fetchAddr < 32'(progWords * 4)) begin
            fetchInst <= progMem[fetchAddr[7:2]];
        end else begin
            fetchInst <= fetchAddr ^ 32'h13a5_c3f0;   // past the end and always flushed
        end
    end

    pipelineCore dut (
        .clk(clk),
        .reset(reset),
        .fetchAddr(fetchAddr),
        .fetchInst(fetchInst),
        .fetchReady(fetchReady),
        .retireValid(retireValid),
        .retirePc(retirePc),
        .retireRd(retireRd),
        .retireData(retireData),
        .retireReady(retireReady)
    );

    retireChecker #(.progWords(progWords)) retireCheck (
        .clk(clk),
        .reset(reset),
        .progMem(progMem),
        .fetchAddr(fetchAddr),
        .retireValid(retireValid),
        .retirePc(retirePc),
        .retireRd(retireRd),
        .retireData(retireData),
        .retireReady(retireReady),
        .retiredCount(retiredCount),
        .errorCount(errorCount)
    );

    // small regSpan gives long dependency chains
    task automatic buildProgram(input int regSpan, input bit withBranches);
        logic [31:0] r1;
        logic [31:0] r2;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [20:0] off;
        int kind;
        int hop;
        for (int i = 0; i < progWords - 1; i++) begin
            progRng = nextRandom(progRng);
            r1 = progRng;
            progRng = nextRandom(progRng);
            r2 = progRng;
            kind = int'(r1[31:28]);
            if (!withBranches && kind >= 12 && kind <= 14) kind = kind - 6;
            rd = 5'(int'(r1[27:24]) % regSpan);
            rs1 = 5'(int'(r1[23:20]) % regSpan);
            rs2 = 5'(int'(r1[19:16]) % regSpan);
            hop = 1 + int'(r2[5:4]);   // forward only and never past the last word
            if (i + hop > progWords - 1) hop = progWords - 1 - i;
            off = 21'(hop * 4);
            case (kind)
                0: progMem[i] = {r2[31:12], rd, opLui};
                1, 15: progMem[i] = {r2[31:20], rs1, 3'b000, rd, opImm};
                2: progMem[i] = {r2[31:20], rs1, 3'b100, rd, opImm};
                3: progMem[i] = {r2[31:20], rs1, 3'b110, rd, opImm};
                4: progMem[i] = {r2[31:20], rs1, 3'b111, rd, opImm};
                5: progMem[i] = {r2[31:20], rs1, 3'b010, rd, opImm};
                6: progMem[i] = {7'b0000000, rs2, rs1, 3'b000, rd, opReg};
                7: progMem[i] = {7'b0100000, rs2, rs1, 3'b000, rd, opReg};
                8: progMem[i] = {7'b0000000, rs2, rs1, 3'b111, rd, opReg};
                9: progMem[i] = {7'b0000000, rs2, rs1, 3'b110, rd, opReg};
                10: progMem[i] = {7'b0000000, rs2, rs1, 3'b100, rd, opReg};
                11: progMem[i] = {7'b0000000, rs2, rs1, 3'b010, rd, opReg};
                12: progMem[i] = {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11],
                                  opBranch};
                13: progMem[i] = {off[12], off[10:5], rs2, rs1, 3'b001, off[4:1], off[11],
                                  opBranch};
                default: progMem[i] = {off[20], off[10:1], off[11], off[19:12], rd, opJal};
            endcase
        end
        progMem[progWords - 1] = {25'd0, opJal};   // jal x0, 0 parks the core
    endtask

    task automatic waitRetired(input int target, output bit ok);
        ok = 1'b0;
        for (int cycles = 0; cycles < waitLimit; cycles++) begin
            @(negedge clk);
            if (retiredCount >= target) begin
                ok = 1'b1;
                break;
            end
        end
    endtask

    task automatic runTest(input string name, input int regSpan, input bit withBranches,
                           input int fetchPct, input int retirePct);
        int errorsBefore;
        bit ok;
        errorsBefore = errorCount;
        @(negedge clk);
        reset = 1'b1;
        fetchStallPct = fetchPct;
        retireStallPct = retirePct;
        buildProgram(regSpan, withBranches);
        repeat (3) @(negedge clk);
        reset = 1'b0;
        waitRetired(retireTarget, ok);
        testsRun++;
        if (!ok) begin
            $display("test %s: timed out with only %0d of %0d instructions retired",
                     name, retiredCount, retireTarget);
            testsBad++;
        end else if (errorCount != errorsBefore) begin
            $display("test %s: %0d mismatches", name, errorCount - errorsBefore);
            testsBad++;
        end else begin
            $display("test %s: ok, %0d instructions retired", name, retiredCount);
        end
    endtask

    initial begin
        runTest("straightLine", 16, 1'b0, 0, 0);
        runTest("dependentChain", 4, 1'b0, 0, 0);
        runTest("branchJump", 8, 1'b1, 0, 0);
        runTest("fetchStall", 8, 1'b1, 30, 0);
        runTest("retireStall", 8, 1'b1, 0, 30);
        runTest("mixedStall", 4, 1'b1, 25, 25);
        $display("%0d tests run, %0d passed, %0d with errors, %0d mismatches in total",
                 testsRun, testsRun - testsBad, testsBad, errorCount);
        if (testsBad == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
source/coreTypes.sv
source/writebackIf.sv
source/stageRegister.sv
source/fetchUnit.sv
source/registerFile.sv
source/decodeUnit.sv
source/executeUnit.sv
source/pipelineCore.sv
verification/retireChecker.sv
verification/coreTb.sv

// File: run.sh
#!/bin/sh
# build and run the pipeline core testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/10ps -Wno-fatal --top-module coreTb -f compile.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/VcoreTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^all tests passed$" sim.log; then
    exit 0
fi
exit 1
